//--- cmd_fetch.sv
`timescale 1ns/10ps
`default_nettype none

module cmd_fetch (
  input  wire                 clk,
  input  wire                 rst,
  input  wire                 fetch_go,
  input  wire mem_pkg::addr_t base_addr,
  output mem_pkg::word_t      cmd_word,
  output logic                op_done,
  output logic                bus_read_q,
  output logic                bus_write_q,
  output mem_pkg::addr_t      bus_addr,
  output mem_pkg::word_t      bus_data_out,
  input  wire mem_pkg::word_t data_in,
  input  wire                 read_dn,
  input  wire                 write_dn
);

  // ip read, command read, ip write back
  typedef enum logic [1:0] {
    st_idle,
    st_ip_rd,
    st_cmd_rd,
    st_ip_wr
  } fetch_state_e;

  fetch_state_e   state;
  mem_pkg::word_t ip_val;
  mem_pkg::addr_t ip_addr;

  assign ip_addr = base_addr + mem_pkg::addr_t'(mem_pkg::ip_reg_num);

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= st_idle;
      op_done     <= 1'b0;
      bus_read_q  <= 1'b0;
      bus_write_q <= 1'b0;
    end else begin
      op_done <= 1'b0;
      case (state)
        st_idle: begin
          if (fetch_go) begin
            state <= st_ip_rd;
          end
        end

        st_ip_rd: begin
          if (!bus_read_q) begin
            bus_read_q <= 1'b1;
            bus_addr   <= ip_addr;
          end else if (read_dn) begin
            bus_read_q <= 1'b0;
            ip_val     <= data_in;
            state      <= st_cmd_rd;
          end
        end

        st_cmd_rd: begin
          if (!bus_read_q) begin
            bus_read_q <= 1'b1;
            bus_addr   <= mem_pkg::addr_t'(ip_val);
          end else if (read_dn) begin
            // held for decode until the next fetch
            bus_read_q <= 1'b0;
            cmd_word   <= data_in;
            state      <= st_ip_wr;
          end
        end

        st_ip_wr: begin
          if (!bus_write_q) begin
            bus_write_q  <= 1'b1;
            bus_addr     <= ip_addr;
            bus_data_out <= ip_val + mem_pkg::word_t'(1);
          end else if (write_dn) begin
            bus_write_q <= 1'b0;
            op_done     <= 1'b1;
            state       <= st_idle;
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- cmd_pkg.sv
`default_nettype none

package cmd_pkg;

  // sixteen registers, all held in data memory
  typedef logic [3:0] reg_num_t;

  // lowest bit of each register number field
  localparam int src1_num_lsb = 0;
  localparam int src0_num_lsb = 4;
  localparam int dst_num_lsb  = 8;

  // pointer flags, one per operand
  localparam int src1_ptr_bit = 16;
  localparam int src0_ptr_bit = 17;
  localparam int dst_ptr_bit  = 18;

  // 2-bit post-modify fields
  localparam int src1_mode_lsb = 20;
  localparam int src0_mode_lsb = 22;
  localparam int dst_mode_lsb  = 24;

  // opcode in the top nibble
  localparam int cmd_code_lsb = 28;

  // reserved code behaves as none
  typedef enum logic [1:0] {
    mode_none     = 2'd0,
    mode_post_inc = 2'd1,
    mode_post_dec = 2'd2,
    mode_reserved = 2'd3
  } addr_mode_e;

  // work items handed to an operand slot
  typedef enum logic [1:0] {
    op_null,
    op_fetch,
    op_store,
    op_update
  } reg_op_e;

  // instruction phases, order matters for the sequencer
  typedef enum logic [3:0] {
    ph_idle,
    ph_fetch_cmd,
    ph_read_src1,
    ph_read_src0,
    ph_exec,
    ph_store_dst,
    ph_update_dst,
    ph_update_src1,
    ph_update_src0,
    ph_finish
  } phase_e;

endpackage

`default_nettype wire

//--- files.f
mem_pkg.sv
cmd_pkg.sv
operand_slot.sv
cmd_fetch.sv
phase_sequencer.sv
mem_manager.sv
mem_model.sv
mem_manager_props.sv
mem_manager_tb.sv

//--- mem_manager.sv
`timescale 1ns/10ps
`default_nettype none

module mem_manager (
  input  wire                 clk,
  input  wire                 rst,
  input  wire                 start,
  input  wire mem_pkg::addr_t base_addr,
  output wire                 read_q,
  output wire                 write_q,
  output wire mem_pkg::addr_t addr,
  output wire mem_pkg::word_t data_out,
  input  wire mem_pkg::word_t data_in,
  input  wire                 read_dn,
  input  wire                 write_dn,
  output wire                 exec_valid,
  output wire [3:0]           cmd_code,
  output wire mem_pkg::word_t src1_val,
  output wire mem_pkg::word_t src0_val,
  input  wire mem_pkg::word_t result,
  input  wire                 result_valid,
  output wire                 busy,
  output wire                 done
);

  // command fetch unit
  wire mem_pkg::word_t cmd_word;
  wire                 fetch_go, fetch_done;
  wire                 fetch_read_q, fetch_write_q, fetch_read_dn, fetch_write_dn;
  wire mem_pkg::addr_t fetch_addr;
  wire mem_pkg::word_t fetch_data_out;

  // source 1 slot
  wire cmd_pkg::reg_op_e    src1_op;
  wire cmd_pkg::reg_num_t   src1_num;
  wire cmd_pkg::addr_mode_e src1_mode;
  wire                      src1_ptr, src1_done;
  wire                      src1_read_q, src1_write_q, src1_read_dn, src1_write_dn;
  wire mem_pkg::addr_t      src1_addr;
  wire mem_pkg::word_t      src1_data_out;

  // source 0 slot
  wire cmd_pkg::reg_op_e    src0_op;
  wire cmd_pkg::reg_num_t   src0_num;
  wire cmd_pkg::addr_mode_e src0_mode;
  wire                      src0_ptr, src0_done;
  wire                      src0_read_q, src0_write_q, src0_read_dn, src0_write_dn;
  wire mem_pkg::addr_t      src0_addr;
  wire mem_pkg::word_t      src0_data_out;

  // destination slot
  wire cmd_pkg::reg_op_e    dst_op;
  wire cmd_pkg::reg_num_t   dst_num;
  wire cmd_pkg::addr_mode_e dst_mode;
  wire                      dst_ptr, dst_done;
  wire                      dst_read_q, dst_write_q, dst_read_dn, dst_write_dn;
  wire mem_pkg::addr_t      dst_addr;
  wire mem_pkg::word_t      dst_data_out;

  cmd_fetch u_cmd_fetch (
    .clk          (clk),
    .rst          (rst),
    .fetch_go     (fetch_go),
    .base_addr    (base_addr),
    .cmd_word     (cmd_word),
    .op_done      (fetch_done),
    .bus_read_q   (fetch_read_q),
    .bus_write_q  (fetch_write_q),
    .bus_addr     (fetch_addr),
    .bus_data_out (fetch_data_out),
    .data_in      (data_in),
    .read_dn      (fetch_read_dn),
    .write_dn     (fetch_write_dn)
  );

  // sources are never stored to
  operand_slot u_src1_slot (
    .clk          (clk),
    .rst          (rst),
    .reg_op       (src1_op),
    .reg_num      (src1_num),
    .is_ptr       (src1_ptr),
    .mode         (src1_mode),
    .base_addr    (base_addr),
    .store_data   ('0),
    .operand      (src1_val),
    .op_done      (src1_done),
    .bus_read_q   (src1_read_q),
    .bus_write_q  (src1_write_q),
    .bus_addr     (src1_addr),
    .bus_data_out (src1_data_out),
    .data_in      (data_in),
    .read_dn      (src1_read_dn),
    .write_dn     (src1_write_dn)
  );

  operand_slot u_src0_slot (
    .clk          (clk),
    .rst          (rst),
    .reg_op       (src0_op),
    .reg_num      (src0_num),
    .is_ptr       (src0_ptr),
    .mode         (src0_mode),
    .base_addr    (base_addr),
    .store_data   ('0),
    .operand      (src0_val),
    .op_done      (src0_done),
    .bus_read_q   (src0_read_q),
    .bus_write_q  (src0_write_q),
    .bus_addr     (src0_addr),
    .bus_data_out (src0_data_out),
    .data_in      (data_in),
    .read_dn      (src0_read_dn),
    .write_dn     (src0_write_dn)
  );

  // destination value is not needed outside
  operand_slot u_dst_slot (
    .clk          (clk),
    .rst          (rst),
    .reg_op       (dst_op),
    .reg_num      (dst_num),
    .is_ptr       (dst_ptr),
    .mode         (dst_mode),
    .base_addr    (base_addr),
    .store_data   (result),
    .operand      (),
    .op_done      (dst_done),
    .bus_read_q   (dst_read_q),
    .bus_write_q  (dst_write_q),
    .bus_addr     (dst_addr),
    .bus_data_out (dst_data_out),
    .data_in      (data_in),
    .read_dn      (dst_read_dn),
    .write_dn     (dst_write_dn)
  );

  phase_sequencer u_phase_sequencer (
    .clk            (clk),
    .rst            (rst),
    .start          (start),
    .cmd_word       (cmd_word),
    .fetch_go       (fetch_go),
    .fetch_done     (fetch_done),
    .src1_op        (src1_op),
    .src0_op        (src0_op),
    .dst_op         (dst_op),
    .src1_done      (src1_done),
    .src0_done      (src0_done),
    .dst_done       (dst_done),
    .src1_num       (src1_num),
    .src0_num       (src0_num),
    .dst_num        (dst_num),
    .src1_ptr       (src1_ptr),
    .src0_ptr       (src0_ptr),
    .dst_ptr        (dst_ptr),
    .src1_mode      (src1_mode),
    .src0_mode      (src0_mode),
    .dst_mode       (dst_mode),
    .cmd_code       (cmd_code),
    .exec_valid     (exec_valid),
    .result_valid   (result_valid),
    .busy           (busy),
    .done           (done),
    .fetch_read_q   (fetch_read_q),
    .fetch_write_q  (fetch_write_q),
    .fetch_addr     (fetch_addr),
    .fetch_data_out (fetch_data_out),
    .src1_read_q    (src1_read_q),
    .src1_write_q   (src1_write_q),
    .src1_addr      (src1_addr),
    .src1_data_out  (src1_data_out),
    .src0_read_q    (src0_read_q),
    .src0_write_q   (src0_write_q),
    .src0_addr      (src0_addr),
    .src0_data_out  (src0_data_out),
    .dst_read_q     (dst_read_q),
    .dst_write_q    (dst_write_q),
    .dst_addr       (dst_addr),
    .dst_data_out   (dst_data_out),
    .read_q         (read_q),
    .write_q        (write_q),
    .addr           (addr),
    .data_out       (data_out),
    .read_dn        (read_dn),
    .write_dn       (write_dn),
    .fetch_read_dn  (fetch_read_dn),
    .fetch_write_dn (fetch_write_dn),
    .src1_read_dn   (src1_read_dn),
    .src1_write_dn  (src1_write_dn),
    .src0_read_dn   (src0_read_dn),
    .src0_write_dn  (src0_write_dn),
    .dst_read_dn    (dst_read_dn),
    .dst_write_dn   (dst_write_dn)
  );

endmodule

`default_nettype wire

//--- mem_manager_props.sv
`timescale 1ns/10ps
`default_nettype none

module mem_manager_props (
  input wire        clk,
  input wire        rst,
  input wire        read_q,
  input wire        write_q,
  input wire [31:0] addr,
  input wire        read_dn,
  input wire        write_dn,
  input wire        exec_valid,
  input wire        result_valid,
  input wire        done
);

  // one request kind at a time
  a_one_req: assert property (@(posedge clk) disable iff (rst)
    !(read_q && write_q))
    else $error("read_q and write_q high together");

  // waiting request keeps its address
  a_addr_stable: assert property (@(posedge clk) disable iff (rst)
    (read_q || write_q) && !(read_dn || write_dn) |=> $stable(addr))
    else $error("addr moved while a request waited");

  a_exec_hold: assert property (@(posedge clk) disable iff (rst)
    exec_valid && !result_valid |=> exec_valid)
    else $error("exec_valid dropped before result_valid");

  a_done_pulse: assert property (@(posedge clk) disable iff (rst)
    done |=> !done)
    else $error("done longer than one cycle");

endmodule

bind mem_manager mem_manager_props u_mem_manager_props (
  .clk          (clk),
  .rst          (rst),
  .read_q       (read_q),
  .write_q      (write_q),
  .addr         (addr),
  .read_dn      (read_dn),
  .write_dn     (write_dn),
  .exec_valid   (exec_valid),
  .result_valid (result_valid),
  .done         (done)
);

`default_nettype wire

//--- mem_manager_tb.sv
`timescale 1ns/10ps
`default_nettype none

module mem_manager_tb;

  localparam int n_rows = 5;
  localparam int period = 100;

  // one instruction: initial words, expected operands and final words
  typedef struct packed {
    logic [31:0]       cmd;
    logic [3:0][7:0]   ia;
    logic [3:0][31:0]  id;
    logic [31:0]       s1;
    logic [31:0]       s0;
    logic [3:0]        code;
    logic [3:0][7:0]   ea;
    logic [3:0][31:0]  ed;
  } row_t;

  row_t rows [n_rows];

  logic        clk = 1'b0;
  logic        rst = 1'b1;
  logic        start = 1'b0;
  logic [31:0] base_addr = 32'h40;
  logic [31:0] result = '0;
  logic        result_valid = 1'b0;

  wire        read_q, write_q, read_dn, write_dn;
  wire [31:0] addr, data_out, data_in;
  wire        exec_valid, busy, done;
  wire [3:0]  cmd_code;
  wire [31:0] src1_val, src0_val;

  // operands as seen by the execution unit
  logic [31:0] seen_src1, seen_src0;
  logic [3:0]  seen_code;

  always #(period / 2) clk = ~clk;

  mem_manager u_mem_manager (
    .clk          (clk),
    .rst          (rst),
    .start        (start),
    .base_addr    (base_addr),
    .read_q       (read_q),
    .write_q      (write_q),
    .addr         (addr),
    .data_out     (data_out),
    .data_in      (data_in),
    .read_dn      (read_dn),
    .write_dn     (write_dn),
    .exec_valid   (exec_valid),
    .cmd_code     (cmd_code),
    .src1_val     (src1_val),
    .src0_val     (src0_val),
    .result       (result),
    .result_valid (result_valid),
    .busy         (busy),
    .done         (done)
  );

  mem_model u_mem_model (
    .clk      (clk),
    .rst      (rst),
    .read_q   (read_q),
    .write_q  (write_q),
    .addr     (addr),
    .data_out (data_out),
    .data_in  (data_in),
    .read_dn  (read_dn),
    .write_dn (write_dn)
  );

  // execution unit, answers in the cycle after exec_valid
  always @(posedge clk) begin
    #1;
    if (exec_valid && !result_valid) begin
      seen_src1    = src1_val;
      seen_src0    = src0_val;
      seen_code    = cmd_code;
      result       = src1_val + src0_val + {28'd0, cmd_code};
      result_valid = 1'b1;
    end else begin
      result_valid = 1'b0;
    end
  end

  // generous bound, far above a slow instruction
  initial begin
    #(n_rows * 200 * period);
    $display("test failed");
    $fatal(1, "timeout, done never came for all instructions");
  end

  task automatic compare(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
    if (expected !== actual) begin
      $display("Fail %s expected %h actual %h", name, expected, actual);
      $display("test failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  initial begin
    // direct operands, code 3
    rows[0] = '{cmd: 32'h3000_0210,
                ia: {8'h40, 8'h41, 8'h42, 8'h40},
                id: {32'h100, 32'h20, 32'h7, 32'h100},
                s1: 32'h100, s0: 32'h20, code: 4'h3,
                ea: {8'h40, 8'h41, 8'h42, 8'h42},
                ed: {32'h100, 32'h20, 32'h123, 32'h123}};
    // pointer sources, post inc and post dec
    rows[1] = '{cmd: 32'h5093_0654,
                ia: {8'h44, 8'h45, 8'h80, 8'h90},
                id: {32'h80, 32'h90, 32'h1111, 32'h2222},
                s1: 32'h1111, s0: 32'h2222, code: 4'h5,
                ea: {8'h44, 8'h45, 8'h46, 8'h80},
                ed: {32'h81, 32'h8f, 32'h3338, 32'h1111}};
    // mode 3 as none, direct post mode ignored, pointer dst
    rows[2] = '{cmd: 32'hA175_0987,
                ia: {8'h47, 8'hA0, 8'h48, 8'h49},
                id: {32'hA0, 32'h500, 32'h60, 32'hB0},
                s1: 32'h500, s0: 32'h60, code: 4'hA,
                ea: {8'h47, 8'h48, 8'hB0, 8'h49},
                ed: {32'hA0, 32'h60, 32'h56A, 32'hB1}};
    // all three on r3, src0 writes last
    rows[3] = '{cmd: 32'h1197_0333,
                ia: {8'h43, 8'hC0, 8'h43, 8'hC0},
                id: {32'hC0, 32'h7, 32'hC0, 32'h7},
                s1: 32'h7, s0: 32'h7, code: 4'h1,
                ea: {8'h43, 8'hC0, 8'h43, 8'hC0},
                ed: {32'hBF, 32'hF, 32'hBF, 32'hF}};
    // dst overwrites src1 register
    rows[4] = '{cmd: 32'hF002_0ABA,
                ia: {8'h4A, 8'h4B, 8'hD0, 8'h4A},
                id: {32'h1000, 32'hD0, 32'h2000, 32'h1000},
                s1: 32'h1000, s0: 32'h2000, code: 4'hF,
                ea: {8'h4A, 8'h4B, 8'hD0, 8'h4A},
                ed: {32'h300F, 32'hD0, 32'h2000, 32'h300F}};

    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
    compare("reset read_q", 32'd0, {31'd0, read_q});
    compare("reset write_q", 32'd0, {31'd0, write_q});
    compare("reset exec_valid", 32'd0, {31'd0, exec_valid});
    compare("reset busy", 32'd0, {31'd0, busy});
    compare("reset done", 32'd0, {31'd0, done});

    for (int r = 0; r < n_rows; r++) begin
      // fill depends on every address bit
      for (int i = 0; i < 256; i++) begin
        u_mem_model.mem[i] = 32'h5A00_0000 | (i * 32'h0101);
      end
      u_mem_model.mem[8'h4F] = 32'h10;
      u_mem_model.mem[8'h10] = rows[r].cmd;
      for (int k = 0; k < 4; k++) begin
        u_mem_model.mem[rows[r].ia[k]] = rows[r].id[k];
      end

      start = 1'b1;
      tick();
      start = 1'b0;
      tick();
      compare($sformatf("row %0d busy", r), 32'd1, {31'd0, busy});
      // second start lands mid instruction
      start = 1'b1;
      tick();
      start = 1'b0;
      while (!done) begin
        tick();
      end

      compare($sformatf("row %0d src1_val", r), rows[r].s1, seen_src1);
      compare($sformatf("row %0d src0_val", r), rows[r].s0, seen_src0);
      compare($sformatf("row %0d cmd_code", r), {28'd0, rows[r].code}, {28'd0, seen_code});
      compare($sformatf("row %0d ip", r), 32'h11, u_mem_model.mem[8'h4F]);
      for (int k = 0; k < 4; k++) begin
        compare($sformatf("row %0d word %h", r, rows[r].ea[k]), rows[r].ed[k],
                u_mem_model.mem[rows[r].ea[k]]);
      end
      tick();
      compare($sformatf("row %0d idle busy", r), 32'd0, {31'd0, busy});
    end

    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- mem_model.sv
`timescale 1ns/10ps
`default_nettype none

module mem_model (
  input  wire         clk,
  input  wire         rst,
  input  wire         read_q,
  input  wire         write_q,
  input  wire  [31:0] addr,
  input  wire  [31:0] data_out,
  output logic [31:0] data_in = '0,
  output logic        read_dn = 1'b0,
  output logic        write_dn = 1'b0
);

  // 256 words, upper address bits ignored
  logic [31:0] mem [0:255];

  integer seed = 84;
  int     wait_cnt = 0;

  // answers one request at a time, 0 to 3 cycles late
  always @(posedge clk) begin
    #1;
    if (rst || read_dn || write_dn) begin
      // done lasts one cycle, then a fresh delay for the next request
      read_dn  = 1'b0;
      write_dn = 1'b0;
      wait_cnt = $unsigned($random(seed)) % 4;
    end else if (read_q || write_q) begin
      if (wait_cnt == 0) begin
        if (read_q) begin
          data_in = mem[addr[7:0]];
          read_dn = 1'b1;
        end else begin
          mem[addr[7:0]] = data_out;
          write_dn       = 1'b1;
        end
      end else begin
        wait_cnt = wait_cnt - 1;
      end
    end
  end

endmodule

`default_nettype wire

//--- mem_pkg.sv
`default_nettype none

package mem_pkg;

  // word addressed data memory
  localparam int addr_width = 32;
  localparam int data_width = 32;

  typedef logic [addr_width-1:0] addr_t;
  typedef logic [data_width-1:0] word_t;

  // instruction pointer lives in the last register slot
  localparam logic [3:0] ip_reg_num = 4'd15;

endpackage

`default_nettype wire

//--- operand_slot.sv
`timescale 1ns/10ps
`default_nettype none

module operand_slot (
  input  wire                     clk,
  input  wire                     rst,
  input  wire cmd_pkg::reg_op_e   reg_op,
  input  wire cmd_pkg::reg_num_t  reg_num,
  input  wire                     is_ptr,
  input  wire cmd_pkg::addr_mode_e mode,
  input  wire mem_pkg::addr_t     base_addr,
  input  wire mem_pkg::word_t     store_data,
  output mem_pkg::word_t          operand,
  output logic                    op_done,
  output logic                    bus_read_q,
  output logic                    bus_write_q,
  output mem_pkg::addr_t          bus_addr,
  output mem_pkg::word_t          bus_data_out,
  input  wire mem_pkg::word_t     data_in,
  input  wire                     read_dn,
  input  wire                     write_dn
);

  // register read, pointee read, one write
  typedef enum logic [1:0] {
    st_idle,
    st_reg_rd,
    st_ptr_rd,
    st_wr
  } slot_state_e;

  slot_state_e    state;
  logic           storing;
  mem_pkg::word_t reg_val;
  mem_pkg::word_t wr_val;
  mem_pkg::addr_t reg_addr;
  logic           post_mode;

  // register home in memory
  assign reg_addr = base_addr + mem_pkg::addr_t'(reg_num);

  // reserved mode counts as none
  assign post_mode = (mode == cmd_pkg::mode_post_inc) ||
                     (mode == cmd_pkg::mode_post_dec);

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= st_idle;
      storing     <= 1'b0;
      op_done     <= 1'b0;
      bus_read_q  <= 1'b0;
      bus_write_q <= 1'b0;
    end else begin
      op_done <= 1'b0;
      case (state)
        st_idle: begin
          case (reg_op)
            cmd_pkg::op_fetch: begin
              storing <= 1'b0;
              state   <= st_reg_rd;
            end
            cmd_pkg::op_store: begin
              // result valid in this cycle only
              storing <= 1'b1;
              wr_val  <= store_data;
              state   <= is_ptr ? st_reg_rd : st_wr;
            end
            cmd_pkg::op_update: begin
              storing <= 1'b0;
              wr_val  <= (mode == cmd_pkg::mode_post_dec) ? reg_val - mem_pkg::word_t'(1)
                                                          : reg_val + mem_pkg::word_t'(1);
              if (is_ptr && post_mode) begin
                state <= st_wr;
              end else begin
                // nothing to write back
                op_done <= 1'b1;
              end
            end
            default: begin
            end
          endcase
        end

        st_reg_rd: begin
          if (!bus_read_q) begin
            bus_read_q <= 1'b1;
            bus_addr   <= reg_addr;
          end else if (read_dn) begin
            bus_read_q <= 1'b0;
            reg_val    <= data_in;
            if (storing) begin
              state <= st_wr;
            end else if (is_ptr) begin
              state <= st_ptr_rd;
            end else begin
              // direct operand is the register itself
              operand <= data_in;
              op_done <= 1'b1;
              state   <= st_idle;
            end
          end
        end

        st_ptr_rd: begin
          if (!bus_read_q) begin
            bus_read_q <= 1'b1;
            bus_addr   <= mem_pkg::addr_t'(reg_val);
          end else if (read_dn) begin
            bus_read_q <= 1'b0;
            operand    <= data_in;
            op_done    <= 1'b1;
            state      <= st_idle;
          end
        end

        st_wr: begin
          if (!bus_write_q) begin
            bus_write_q  <= 1'b1;
            bus_data_out <= wr_val;
            // pointer store targets the pointee and all else the register
            bus_addr     <= (storing && is_ptr) ? mem_pkg::addr_t'(reg_val) : reg_addr;
          end else if (write_dn) begin
            bus_write_q <= 1'b0;
            op_done     <= 1'b1;
            state       <= st_idle;
          end
        end

        default: state <= st_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- phase_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module phase_sequencer (
  input  wire                 clk,
  input  wire                 rst,
  input  wire                 start,
  input  wire mem_pkg::word_t cmd_word,
  output logic                fetch_go,
  input  wire                 fetch_done,
  output cmd_pkg::reg_op_e    src1_op,
  output cmd_pkg::reg_op_e    src0_op,
  output cmd_pkg::reg_op_e    dst_op,
  input  wire                 src1_done,
  input  wire                 src0_done,
  input  wire                 dst_done,
  output cmd_pkg::reg_num_t   src1_num,
  output cmd_pkg::reg_num_t   src0_num,
  output cmd_pkg::reg_num_t   dst_num,
  output logic                src1_ptr,
  output logic                src0_ptr,
  output logic                dst_ptr,
  output cmd_pkg::addr_mode_e src1_mode,
  output cmd_pkg::addr_mode_e src0_mode,
  output cmd_pkg::addr_mode_e dst_mode,
  output logic [3:0]          cmd_code,
  output logic                exec_valid,
  input  wire                 result_valid,
  output logic                busy,
  output logic                done,
  input  wire                 fetch_read_q,
  input  wire                 fetch_write_q,
  input  wire mem_pkg::addr_t fetch_addr,
  input  wire mem_pkg::word_t fetch_data_out,
  input  wire                 src1_read_q,
  input  wire                 src1_write_q,
  input  wire mem_pkg::addr_t src1_addr,
  input  wire mem_pkg::word_t src1_data_out,
  input  wire                 src0_read_q,
  input  wire                 src0_write_q,
  input  wire mem_pkg::addr_t src0_addr,
  input  wire mem_pkg::word_t src0_data_out,
  input  wire                 dst_read_q,
  input  wire                 dst_write_q,
  input  wire mem_pkg::addr_t dst_addr,
  input  wire mem_pkg::word_t dst_data_out,
  output logic                read_q,
  output logic                write_q,
  output mem_pkg::addr_t      addr,
  output mem_pkg::word_t      data_out,
  input  wire                 read_dn,
  input  wire                 write_dn,
  output logic                fetch_read_dn,
  output logic                fetch_write_dn,
  output logic                src1_read_dn,
  output logic                src1_write_dn,
  output logic                src0_read_dn,
  output logic                src0_write_dn,
  output logic                dst_read_dn,
  output logic                dst_write_dn
);

  cmd_pkg::phase_e phase;
  logic            advance;

  // field decode, command word is stable after the fetch
  assign src1_num  = cmd_pkg::reg_num_t'(cmd_word >> cmd_pkg::src1_num_lsb);
  assign src0_num  = cmd_pkg::reg_num_t'(cmd_word >> cmd_pkg::src0_num_lsb);
  assign dst_num   = cmd_pkg::reg_num_t'(cmd_word >> cmd_pkg::dst_num_lsb);
  assign src1_ptr  = cmd_word[cmd_pkg::src1_ptr_bit];
  assign src0_ptr  = cmd_word[cmd_pkg::src0_ptr_bit];
  assign dst_ptr   = cmd_word[cmd_pkg::dst_ptr_bit];
  assign src1_mode = cmd_pkg::addr_mode_e'(cmd_word[cmd_pkg::src1_mode_lsb +: 2]);
  assign src0_mode = cmd_pkg::addr_mode_e'(cmd_word[cmd_pkg::src0_mode_lsb +: 2]);
  assign dst_mode  = cmd_pkg::addr_mode_e'(cmd_word[cmd_pkg::dst_mode_lsb +: 2]);
  assign cmd_code  = cmd_word[cmd_pkg::cmd_code_lsb +: 4];

  // each phase ends on its own completion pulse
  always_comb begin
    case (phase)
      cmd_pkg::ph_idle:        advance = start;
      cmd_pkg::ph_fetch_cmd:   advance = fetch_done;
      cmd_pkg::ph_read_src1,
      cmd_pkg::ph_update_src1: advance = src1_done;
      cmd_pkg::ph_read_src0,
      cmd_pkg::ph_update_src0: advance = src0_done;
      cmd_pkg::ph_exec:        advance = result_valid;
      cmd_pkg::ph_store_dst,
      cmd_pkg::ph_update_dst:  advance = dst_done;
      default:                 advance = 1'b1;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      phase <= cmd_pkg::ph_idle;
    end else if (advance) begin
      if (phase == cmd_pkg::ph_finish) begin
        phase <= cmd_pkg::ph_idle;
      end else begin
        phase <= cmd_pkg::phase_e'(phase + 4'd1);
      end
    end
  end

  // next unit starts on the edge that closes the current phase
  assign fetch_go = (phase == cmd_pkg::ph_idle) && start;

  assign src1_op = (phase == cmd_pkg::ph_fetch_cmd && fetch_done) ? cmd_pkg::op_fetch :
                   (phase == cmd_pkg::ph_update_dst && dst_done)  ? cmd_pkg::op_update :
                                                                    cmd_pkg::op_null;

  assign src0_op = (phase == cmd_pkg::ph_read_src1 && src1_done)   ? cmd_pkg::op_fetch :
                   (phase == cmd_pkg::ph_update_src1 && src1_done) ? cmd_pkg::op_update :
                                                                     cmd_pkg::op_null;

  // dst slot latches result while result_valid is high
  assign dst_op = (phase == cmd_pkg::ph_exec && result_valid)   ? cmd_pkg::op_store :
                  (phase == cmd_pkg::ph_store_dst && dst_done)  ? cmd_pkg::op_update :
                                                                  cmd_pkg::op_null;

  assign exec_valid = (phase == cmd_pkg::ph_exec);
  assign busy       = (phase != cmd_pkg::ph_idle);
  assign done       = (phase == cmd_pkg::ph_finish);

  // bus owner follows the phase, done pulses go back to it alone
  always_comb begin
    read_q         = 1'b0;
    write_q        = 1'b0;
    addr           = '0;
    data_out       = '0;
    fetch_read_dn  = 1'b0;
    fetch_write_dn = 1'b0;
    src1_read_dn   = 1'b0;
    src1_write_dn  = 1'b0;
    src0_read_dn   = 1'b0;
    src0_write_dn  = 1'b0;
    dst_read_dn    = 1'b0;
    dst_write_dn   = 1'b0;
    case (phase)
      cmd_pkg::ph_fetch_cmd: begin
        read_q         = fetch_read_q;
        write_q        = fetch_write_q;
        addr           = fetch_addr;
        data_out       = fetch_data_out;
        fetch_read_dn  = read_dn;
        fetch_write_dn = write_dn;
      end
      cmd_pkg::ph_read_src1,
      cmd_pkg::ph_update_src1: begin
        read_q        = src1_read_q;
        write_q       = src1_write_q;
        addr          = src1_addr;
        data_out      = src1_data_out;
        src1_read_dn  = read_dn;
        src1_write_dn = write_dn;
      end
      cmd_pkg::ph_read_src0,
      cmd_pkg::ph_update_src0: begin
        read_q        = src0_read_q;
        write_q       = src0_write_q;
        addr          = src0_addr;
        data_out      = src0_data_out;
        src0_read_dn  = read_dn;
        src0_write_dn = write_dn;
      end
      cmd_pkg::ph_store_dst,
      cmd_pkg::ph_update_dst: begin
        read_q       = dst_read_q;
        write_q      = dst_write_q;
        addr         = dst_addr;
        data_out     = dst_data_out;
        dst_read_dn  = read_dn;
        dst_write_dn = write_dn;
      end
      default: begin
      end
    endcase
  end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# build and run the mem_manager simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module mem_manager_tb -o sim
status=$?
if [ $status -ne 0 ]; then
  echo "build failed"
  exit $status
fi

./obj_dir/sim
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed"
  exit $status
fi

exit 0
